// ==== src/bp_pkg.sv ====
// branch predictor package with opcode and state encodings and the fetch/execute structs
package bp_pkg;

    // address and target width
    localparam int BP_XLEN = 32;

    // major opcodes that the predictor tells apart
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } bp_opcode_e;

    // init sequence after reset
    typedef enum logic [1:0] {
        ST_RESET = 2'd0,
        ST_SWEEP = 2'd1,
        ST_READY = 2'd2
    } bp_state_e;

    // resolved control transfer coming back from execute
    typedef struct packed {
        logic               valid;
        logic [BP_XLEN-1:0] pc;
        logic [BP_XLEN-1:0] target;
        // raw opcode, any value outside bp_opcode_e is ignored
        logic [6:0]         op;
        logic               taken;
    } bp_update_t;

    // prediction handed to fetch
    typedef struct packed {
        logic               hit;
        logic               taken;
        logic [BP_XLEN-1:0] target;
    } bp_pred_t;

endpackage

// ==== src/bp_init_fsm.sv ====
// init FSM that sweeps the predictor tables after reset and then opens lookups and updates
`timescale 1ns/1ps

module bp_init_fsm (
    input  logic clk,
    input  logic rst_n_i,
    input  logic count_done_i,
    input  logic upd_valid_i,
    output logic count_en_o,
    output logic sweep_we_o,
    output logic lookup_en_o,
    output logic upd_en_o,
    output logic ready_o
);

    import bp_pkg::*;

    bp_state_e state_q;
    bp_state_e state_d;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RESET: begin
                state_d = ST_SWEEP;
            end
            ST_SWEEP: begin
                // the edge that writes the last index finishes the sweep
                if (count_done_i) begin
                    state_d = ST_READY;
                end
            end
            ST_READY: begin
                state_d = ST_READY;
            end
            default: begin
                state_d = ST_RESET;
            end
        endcase
    end

    // counter and table writes only run together
    assign count_en_o  = (state_q == ST_SWEEP);
    assign sweep_we_o  = (state_q == ST_SWEEP);

    assign ready_o     = (state_q == ST_READY);
    assign lookup_en_o = ready_o;
    // updates offered before ready are dropped, there is no back-pressure
    assign upd_en_o    = upd_valid_i && ready_o;

endmodule

// ==== src/bp_sweep_counter.sv ====
// index counter that walks the table entries during the init sweep
`timescale 1ns/1ps

module bp_sweep_counter #(
    parameter int COUNT_LEN = 32
) (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         count_en_i,
    output logic [$clog2(COUNT_LEN)-1:0] idx_o,
    output logic                         count_done_o
);

    localparam int IDX_W = $clog2(COUNT_LEN);

    logic [IDX_W-1:0] idx_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            idx_q <= '0;
        end else if (count_en_i) begin
            if (count_done_o) begin
                idx_q <= '0;
            end else begin
                idx_q <= idx_q + IDX_W'(1);
            end
        end
    end

    // terminal count while the last index is being written
    assign count_done_o = (idx_q == IDX_W'(COUNT_LEN - 1));
    assign idx_o        = idx_q;

endmodule

// ==== src/bp_btb.sv ====
// direct-mapped branch target buffer with tag compare and jump/branch class bits
`timescale 1ns/1ps

module bp_btb #(
    parameter int ENTRIES = 32,
    parameter int IDX_W   = 5
) (
    input  logic                           clk,
    input  logic                           sweep_we_i,
    input  logic [IDX_W-1:0]               sweep_idx_i,
    input  logic                           lookup_en_i,
    input  logic [bp_pkg::BP_XLEN-1:0]     pc_i,
    input  logic                           upd_en_i,
    input  bp_pkg::bp_update_t             upd_i,
    input  logic                           dir_taken_i,
    output bp_pkg::bp_pred_t               pred_o
);

    import bp_pkg::*;

    localparam int BTB_IDX_W = $clog2(ENTRIES);
    localparam int TAG_W     = BP_XLEN - BTB_IDX_W - 2;

    typedef struct packed {
        logic               valid;
        logic               jump;
        logic               branch;
        logic [TAG_W-1:0]   tag;
        logic [BP_XLEN-1:0] target;
    } btb_entry_t;

    btb_entry_t table_q [ENTRIES];

    logic [BTB_IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0]     rd_tag;
    btb_entry_t           rd_entry;
    logic                 tag_hit;

    logic [BTB_IDX_W-1:0] wr_idx;
    logic                 upd_jump;
    logic                 upd_branch;
    logic                 sweep_in_range;

    // the sweep may run past the BTB when the PHT is the larger table
    assign sweep_in_range = ({1'b0, sweep_idx_i} < (IDX_W + 1)'(ENTRIES));

    assign upd_jump   = (upd_i.op == OP_JAL) || (upd_i.op == OP_JALR);
    assign upd_branch = (upd_i.op == OP_BRANCH);
    assign wr_idx     = upd_i.pc[BTB_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (sweep_we_i) begin
            if (sweep_in_range) begin
                table_q[sweep_idx_i[BTB_IDX_W-1:0]].valid <= 1'b0;
            end
        end else if (upd_en_i && (upd_jump || upd_branch)) begin
            // always overwrite, a different tag simply evicts the old entry
            table_q[wr_idx].valid  <= 1'b1;
            table_q[wr_idx].jump   <= upd_jump;
            table_q[wr_idx].branch <= upd_branch;
            table_q[wr_idx].tag    <= upd_i.pc[BP_XLEN-1:BTB_IDX_W+2];
            table_q[wr_idx].target <= upd_i.target;
        end
    end

    // lookup path
    assign rd_idx   = pc_i[BTB_IDX_W+1:2];
    assign rd_tag   = pc_i[BP_XLEN-1:BTB_IDX_W+2];
    assign rd_entry = table_q[rd_idx];
    assign tag_hit  = lookup_en_i && rd_entry.valid && (rd_entry.tag == rd_tag);

    always_comb begin
        pred_o = '0;
        if (tag_hit) begin
            pred_o.hit    = 1'b1;
            // jumps are unconditional, branches follow the PHT
            pred_o.taken  = rd_entry.jump || (rd_entry.branch && dir_taken_i);
            pred_o.target = rd_entry.target;
        end
    end

endmodule

// ==== src/bp_gshare_pht.sv ====
// gshare direction predictor with global history register and 2-bit counter table
`timescale 1ns/1ps

module bp_gshare_pht #(
    parameter int GHR_BITS = 5
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       sweep_we_i,
    input  logic [GHR_BITS-1:0]        sweep_idx_i,
    input  logic [bp_pkg::BP_XLEN-1:0] pc_i,
    input  logic                       upd_en_i,
    input  bp_pkg::bp_update_t         upd_i,
    input  logic [GHR_BITS-1:0]        upd_pht_idx_i,
    input  logic                       ghr_clear_i,
    output logic [GHR_BITS-1:0]        pht_idx_o,
    output logic                       dir_taken_o
);

    import bp_pkg::*;

    localparam int PHT_ENTRIES = 1 << GHR_BITS;

    logic [GHR_BITS-1:0] ghr_q;
    logic [1:0]          pht_q [PHT_ENTRIES];

    logic                upd_branch;
    logic [1:0]          upd_cnt;

    assign upd_branch = upd_en_i && (upd_i.op == OP_BRANCH);
    assign upd_cnt    = pht_q[upd_pht_idx_i];

    // history shifts in resolved outcomes, clear wins over a shift
    always_ff @(posedge clk) begin
        if (!rst_n_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (upd_branch) begin
            ghr_q <= {ghr_q[GHR_BITS-2:0], upd_i.taken};
        end
    end

    always_ff @(posedge clk) begin
        if (sweep_we_i) begin
            // weakly not taken
            pht_q[sweep_idx_i] <= 2'b01;
        end else if (upd_branch) begin
            if (upd_i.taken) begin
                if (upd_cnt != 2'b11) begin
                    pht_q[upd_pht_idx_i] <= upd_cnt + 2'd1;
                end
            end else begin
                if (upd_cnt != 2'b00) begin
                    pht_q[upd_pht_idx_i] <= upd_cnt - 2'd1;
                end
            end
        end
    end

    // gshare hash of the word address and the history
    assign pht_idx_o   = pc_i[GHR_BITS+1:2] ^ ghr_q;
    assign dir_taken_o = pht_q[pht_idx_o][1];

endmodule

// ==== src/bp_top.sv ====
// fetch-stage branch predictor top with init sweep, BTB and gshare PHT
`timescale 1ns/1ps

module bp_top #(
    parameter int BTB_ENTRIES = 32,
    parameter int GHR_BITS    = 5
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [bp_pkg::BP_XLEN-1:0] pc_i,
    input  bp_pkg::bp_update_t         upd_i,
    input  logic [GHR_BITS-1:0]        upd_pht_idx_i,
    input  logic                       ghr_clear_i,
    output bp_pkg::bp_pred_t           pred_o,
    output logic [GHR_BITS-1:0]        pht_idx_o,
    output logic                       ready_o
);

    // the sweep covers whichever table is larger
    localparam int PHT_ENTRIES = 1 << GHR_BITS;
    localparam int SWEEP_LEN   = (BTB_ENTRIES > PHT_ENTRIES) ? BTB_ENTRIES : PHT_ENTRIES;
    localparam int SWEEP_IDX_W = $clog2(SWEEP_LEN);

    logic                   count_en;
    logic                   count_done;
    logic                   sweep_we;
    logic                   lookup_en;
    logic                   upd_en;
    logic                   dir_taken;
    logic [SWEEP_IDX_W-1:0] sweep_idx;

    bp_init_fsm u_init_fsm (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .count_done_i (count_done),
        .upd_valid_i  (upd_i.valid),
        .count_en_o   (count_en),
        .sweep_we_o   (sweep_we),
        .lookup_en_o  (lookup_en),
        .upd_en_o     (upd_en),
        .ready_o      (ready_o)
    );

    bp_sweep_counter #(
        .COUNT_LEN (SWEEP_LEN)
    ) u_sweep_counter (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .count_en_i   (count_en),
        .idx_o        (sweep_idx),
        .count_done_o (count_done)
    );

    bp_btb #(
        .ENTRIES (BTB_ENTRIES),
        .IDX_W   (SWEEP_IDX_W)
    ) u_btb (
        .clk         (clk),
        .sweep_we_i  (sweep_we),
        .sweep_idx_i (sweep_idx),
        .lookup_en_i (lookup_en),
        .pc_i        (pc_i),
        .upd_en_i    (upd_en),
        .upd_i       (upd_i),
        .dir_taken_i (dir_taken),
        .pred_o      (pred_o)
    );

    // low index bits reach every counter, a larger BTB just rewrites some twice
    bp_gshare_pht #(
        .GHR_BITS (GHR_BITS)
    ) u_gshare_pht (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .sweep_we_i    (sweep_we),
        .sweep_idx_i   (sweep_idx[GHR_BITS-1:0]),
        .pc_i          (pc_i),
        .upd_en_i      (upd_en),
        .upd_i         (upd_i),
        .upd_pht_idx_i (upd_pht_idx_i),
        .ghr_clear_i   (ghr_clear_i),
        .pht_idx_o     (pht_idx_o),
        .dir_taken_o   (dir_taken)
    );

endmodule

// ==== testbench/bp_assert.sv ====
// concurrent checks on branch predictor invariants, bound into the top level
`timescale 1ns/1ps

module bp_assert (
    input logic               clk,
    input logic               rst_n_i,
    input bp_pkg::bp_pred_t   pred_i,
    input logic               ready_i,
    input logic               upd_en_i,
    input bp_pkg::bp_state_e  fsm_state_i
);

    import bp_pkg::*;

    int fail_count = 0;

    // a taken prediction always comes from a BTB hit
    taken_needs_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
        pred_i.taken |-> pred_i.hit)
        else begin
            fail_count++;
            $error("pred_o.taken is high without pred_o.hit");
        end

    // once ready, only a reset may drop it
    ready_holds: assert property (@(posedge clk) disable iff (!rst_n_i)
        ($past(ready_i) && $past(rst_n_i)) |-> ready_i)
        else begin
            fail_count++;
            $error("ready_o fell without a reset");
        end

    no_update_before_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        (fsm_state_i != ST_READY) |-> !upd_en_i)
        else begin
            fail_count++;
            $error("table update enabled while the init FSM is not ready");
        end

endmodule

bind bp_top bp_assert u_bp_assert (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .pred_i      (pred_o),
    .ready_i     (ready_o),
    .upd_en_i    (upd_en),
    .fsm_state_i (u_init_fsm.state_q)
);

// ==== testbench/bp_tb.sv ====
// testbench for the fetch branch predictor with seeded random traffic and a reference model
`timescale 1ns/1ps

module bp_tb;

    import bp_pkg::*;

    localparam int BTB_ENTRIES   = 32;
    localparam int GHR_BITS      = 5;
    localparam int PHT_ENTRIES   = 1 << GHR_BITS;
    localparam int SWEEP_LEN     = (BTB_ENTRIES > PHT_ENTRIES) ? BTB_ENTRIES : PHT_ENTRIES;
    localparam int BTB_IDX_W     = $clog2(BTB_ENTRIES);
    localparam int READY_TIMEOUT = 4 * SWEEP_LEN;
    localparam int RAND_CYCLES   = 3000;

    logic                clk;
    logic                rst_n_i;
    logic [BP_XLEN-1:0]  pc_i;
    bp_update_t          upd_i;
    logic [GHR_BITS-1:0] upd_pht_idx_i;
    logic                ghr_clear_i;
    bp_pred_t            pred_o;
    logic [GHR_BITS-1:0] pht_idx_o;
    logic                ready_o;

    // reference model state
    logic                model_ready;
    logic                m_valid  [BTB_ENTRIES];
    logic                m_jump   [BTB_ENTRIES];
    logic [BP_XLEN-1:0]  m_tag    [BTB_ENTRIES];
    logic [BP_XLEN-1:0]  m_target [BTB_ENTRIES];
    logic [1:0]          m_cnt    [PHT_ENTRIES];
    logic [GHR_BITS-1:0] m_ghr;

    logic [BP_XLEN-1:0]  pc_pool  [12];
    int                  errors;
    int                  edges;

    bp_top uut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .pc_i          (pc_i),
        .upd_i         (upd_i),
        .upd_pht_idx_i (upd_pht_idx_i),
        .ghr_clear_i   (ghr_clear_i),
        .pred_o        (pred_o),
        .pht_idx_o     (pht_idx_o),
        .ready_o       (ready_o)
    );

    always #2 clk = ~clk;

    function automatic logic [BTB_IDX_W-1:0] btb_index(input logic [BP_XLEN-1:0] pc);
        return pc[BTB_IDX_W+1:2];
    endfunction

    function automatic logic [BP_XLEN-1:0] tag_of(input logic [BP_XLEN-1:0] pc);
        return pc >> (BTB_IDX_W + 2);
    endfunction

    // gshare index taken from the model history
    function automatic logic [GHR_BITS-1:0] hash_index(input logic [BP_XLEN-1:0] pc);
        return pc[GHR_BITS+1:2] ^ m_ghr;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_outputs();
        logic [BTB_IDX_W-1:0] bi;
        logic [GHR_BITS-1:0]  pi;
        logic                 hit;
        logic                 taken;
        bi    = btb_index(pc_i);
        pi    = hash_index(pc_i);
        hit   = model_ready && m_valid[bi] && (m_tag[bi] == tag_of(pc_i));
        taken = hit && (m_jump[bi] || m_cnt[pi][1]);
        check_value("ready_o", 32'(model_ready), 32'(ready_o));
        check_value("pred_o.hit", 32'(hit), 32'(pred_o.hit));
        check_value("pred_o.taken", 32'(taken), 32'(pred_o.taken));
        check_value("pred_o.target", hit ? m_target[bi] : '0, pred_o.target);
        check_value("pht_idx_o", 32'(pi), 32'(pht_idx_o));
    endtask

    // model side of the edge that follows the checks
    task automatic apply_update();
        logic [BTB_IDX_W-1:0] bi;
        logic [1:0]           cnt;
        bi = btb_index(upd_i.pc);
        if (model_ready && upd_i.valid) begin
            if (upd_i.op == OP_JAL || upd_i.op == OP_JALR || upd_i.op == OP_BRANCH) begin
                m_valid[bi]  = 1'b1;
                m_jump[bi]   = (upd_i.op != OP_BRANCH);
                m_tag[bi]    = tag_of(upd_i.pc);
                m_target[bi] = upd_i.target;
            end
            if (upd_i.op == OP_BRANCH) begin
                cnt = m_cnt[upd_pht_idx_i];
                if (upd_i.taken && cnt != 2'b11) begin
                    cnt = cnt + 2'd1;
                end else if (!upd_i.taken && cnt != 2'b00) begin
                    cnt = cnt - 2'd1;
                end
                m_cnt[upd_pht_idx_i] = cnt;
                m_ghr = {m_ghr[GHR_BITS-2:0], upd_i.taken};
            end
        end
        if (ghr_clear_i) begin
            m_ghr = '0;
        end
    endtask

    task automatic cycle(input logic rst_level, input logic [BP_XLEN-1:0] lookup_pc,
                         input logic upd_valid, input logic [BP_XLEN-1:0] upd_pc,
                         input logic [6:0] op, input logic taken,
                         input logic [BP_XLEN-1:0] target, input logic clear);
        @(negedge clk);
        rst_n_i       = rst_level;
        pc_i          = lookup_pc;
        upd_i.valid   = upd_valid;
        upd_i.pc      = upd_pc;
        upd_i.target  = target;
        upd_i.op      = op;
        upd_i.taken   = taken;
        upd_pht_idx_i = hash_index(upd_pc);
        ghr_clear_i   = clear;
        #1;
        compare_outputs();
        apply_update();
    endtask

    task automatic random_cycle(input logic rst_level);
        logic [6:0]  op;
        logic [31:0] rnd;
        logic [31:0] tgt;
        rnd = $urandom;
        tgt = $urandom;
        case (rnd[1:0])
            2'd0: op = OP_BRANCH;
            2'd1: op = OP_JAL;
            2'd2: op = OP_JALR;
            default: op = 7'b0110011;
        endcase
        cycle(rst_level, pc_pool[$urandom_range(11)], ($urandom_range(99) < 60),
              pc_pool[$urandom_range(11)], op, rnd[2], {tgt[31:2], 2'b00},
              ($urandom_range(39) == 0));
    endtask

    task automatic directed_checks();
        // jal on one PC and then its alias with another tag misses
        cycle(1'b1, pc_pool[0], 1'b1, pc_pool[0], OP_JAL, 1'b0, 32'h0000_4400, 1'b0);
        cycle(1'b1, pc_pool[0], 1'b0, pc_pool[0], OP_JAL, 1'b0, '0, 1'b0);
        check_value("jal pred_o.hit", 32'd1, 32'(pred_o.hit));
        check_value("jal pred_o.target", 32'h0000_4400, pred_o.target);
        cycle(1'b1, pc_pool[1], 1'b1, pc_pool[1], OP_JALR, 1'b0, 32'h0000_8800, 1'b0);
        check_value("alias pred_o.hit", 32'd0, 32'(pred_o.hit));
        cycle(1'b1, pc_pool[1], 1'b0, pc_pool[1], OP_JALR, 1'b0, '0, 1'b0);
        check_value("jalr pred_o.taken", 32'd1, 32'(pred_o.taken));
        // history held at zero so the lookup reads the counter just stepped
        cycle(1'b1, pc_pool[4], 1'b0, pc_pool[4], OP_BRANCH, 1'b0, '0, 1'b1);
        cycle(1'b1, pc_pool[4], 1'b1, pc_pool[4], OP_BRANCH, 1'b1, 32'h0000_0200, 1'b1);
        cycle(1'b1, pc_pool[4], 1'b0, pc_pool[4], OP_BRANCH, 1'b0, '0, 1'b0);
        check_value("branch pred_o.taken", 32'd1, 32'(pred_o.taken));
        // non control-transfer opcode must leave the entry alone
        cycle(1'b1, pc_pool[4], 1'b1, pc_pool[4], 7'b0010011, 1'b1, 32'h0000_7700, 1'b0);
        cycle(1'b1, pc_pool[4], 1'b0, pc_pool[4], 7'b0010011, 1'b0, '0, 1'b0);
        check_value("ignored op pred_o.target", 32'h0000_0200, pred_o.target);
    endtask

    initial begin
        void'($urandom(32'hc62f93fe));
        errors        = 0;
        edges         = 0;
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        pc_i          = '0;
        upd_i         = '0;
        upd_pht_idx_i = '0;
        ghr_clear_i   = 1'b0;
        model_ready   = 1'b0;
        m_ghr         = '0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i]  = 1'b0;
            m_jump[i]   = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
        end
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            m_cnt[i] = 2'b01;
        end
        // pairs such as 1000/2000 share a BTB index with different tags
        pc_pool = '{32'h0000_1000, 32'h0000_2000, 32'h0000_1004, 32'h0000_3004,
                    32'h0000_1010, 32'h0000_1014, 32'h0000_1028, 32'h0000_5028,
                    32'h0000_1040, 32'h0000_107c, 32'h8000_007c, 32'h0000_1050};

        // four rising edges in reset and release on the fourth falling edge
        repeat (3) random_cycle(1'b0);
        random_cycle(1'b1);

        while (ready_o !== 1'b1 && edges < READY_TIMEOUT) begin
            edges++;
            model_ready = (edges >= SWEEP_LEN + 1);
            random_cycle(1'b1);
        end

        if (ready_o !== 1'b1) begin
            errors++;
            $display("ready_o stayed low for %0d cycles after reset release", READY_TIMEOUT);
        end else begin
            check_value("ready_o rising edges", SWEEP_LEN + 1, edges);
            model_ready = 1'b1;
            directed_checks();
            repeat (RAND_CYCLES) random_cycle(1'b1);
        end

        errors += uut.u_bp_assert.fail_count;
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
src/bp_pkg.sv
src/bp_init_fsm.sv
src/bp_sweep_counter.sv
src/bp_btb.sv
src/bp_gshare_pht.sv
src/bp_top.sv
testbench/bp_assert.sv
testbench/bp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the branch predictor testbench with Verilator and run it into a log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_MSG="Finished with errors"

verilator --binary --assert --timing -j 0 \
    --top-module bp_tb --Mdir "$BUILD_DIR" -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vbp_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "$FAIL_MSG" "$LOG_FILE"; then
    echo "simulation reported failures, see $LOG_FILE"
    exit 1
fi

echo "simulation passed, log in $LOG_FILE"
exit 0
